/* build.f */
hw/rv_pipe_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/rv_pipe_top.sv
dv/rv_pipe_tb.sv

/* dv/rv_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam int PROG_WORDS = 64;

    localparam logic [4:0] X0 = 5'd0;
    localparam logic [4:0] X5 = 5'd5;
    localparam logic [4:0] X6 = 5'd6;
    localparam logic [4:0] X7 = 5'd7;
    localparam logic [4:0] A0 = 5'd10;

    typedef struct {
        string           name;
        logic [XLEN-1:0] pc;
        instr_u          instr;
        logic [XLEN-1:0] a0;
    } row_t;

    logic            clk;
    logic            reset_i;
    logic [XLEN-1:0] sram_rdata_i;
    logic            sram_data_valid_i;
    logic [XLEN-1:0] sram_addr_o;
    logic            sram_ren_o;
    logic            retire_valid_o;
    logic [XLEN-1:0] retire_pc_o;
    instr_u          retire_instr_o;
    logic [XLEN-1:0] reg_a0_o;

    instr_u          prog [0:PROG_WORDS-1];
    row_t            exp_rows [$];
    integer          seed;
    logic            req_busy;
    logic [1:0]      wait_cnt;
    logic [31:0]     rnd;

    rv_pipe_top #(
        .RESET_PC          ('0)
    ) dut0 (
        .clk               (clk),
        .reset_i           (reset_i),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_addr_o       (sram_addr_o),
        .sram_ren_o        (sram_ren_o),
        .retire_valid_o    (retire_valid_o),
        .retire_pc_o       (retire_pc_o),
        .retire_instr_o    (retire_instr_o),
        .reg_a0_o          (reg_a0_o)
    );

    always #50 clk = ~clk;

    function automatic instr_u reg_op(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
        instr_u w;
        w.r_fmt.funct7 = funct7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = funct3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = OP_REG;
        return w;
    endfunction

    // addi only
    function automatic instr_u imm_op(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [XLEN-1:0] imm);
        instr_u w;
        w.i_fmt.imm12  = imm[11:0];
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = F3_ADD_SUB;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = OP_IMM;
        return w;
    endfunction

    function automatic instr_u upper_imm(input logic [4:0] rd, input logic [19:0] imm20);
        instr_u w;
        w.u_fmt.imm20  = imm20;
        w.u_fmt.rd     = rd;
        w.u_fmt.opcode = OP_LUI;
        return w;
    endfunction

    function automatic instr_u branch_op(input logic [2:0] funct3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [XLEN-1:0] off);
        instr_u w;
        w.b_fmt.imm12   = off[12];
        w.b_fmt.imm10_5 = off[10:5];
        w.b_fmt.rs2     = rs2;
        w.b_fmt.rs1     = rs1;
        w.b_fmt.funct3  = funct3;
        w.b_fmt.imm4_1  = off[4:1];
        w.b_fmt.imm11   = off[11];
        w.b_fmt.opcode  = OP_BRANCH;
        return w;
    endfunction

    function automatic instr_u jump_link(input logic [4:0] rd, input logic [XLEN-1:0] off);
        instr_u w;
        w.j_fmt.imm20    = off[20];
        w.j_fmt.imm10_1  = off[10:1];
        w.j_fmt.imm11    = off[11];
        w.j_fmt.imm19_12 = off[19:12];
        w.j_fmt.rd       = rd;
        w.j_fmt.opcode   = OP_JAL;
        return w;
    endfunction

    // harmless addi x0 whose immediate folds every address bit
    function automatic instr_u fill_word(input logic [XLEN-1:0] addr);
        return imm_op(X0, X0, {20'd0, addr[11:0] ^ addr[23:12] ^ {4'd0, addr[31:24]}});
    endfunction

    function automatic instr_u read_prog(input logic [XLEN-1:0] addr);
        if (addr < XLEN'(PROG_WORDS * 4)) begin
            return prog[addr[7:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic place_word(input logic [XLEN-1:0] pc, input instr_u word);
        prog[pc[7:2]] = word;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = fill_word(XLEN'(i * 4));
        end
        place_word(32'd0,  imm_op(X5, X0, 32'd12));
        place_word(32'd4,  imm_op(X6, X0, -32'sd5));
        place_word(32'd8,  reg_op(F7_BASE, F3_ADD_SUB, A0, X5, X6));
        place_word(32'd12, upper_imm(X7, 20'h12345));
        place_word(32'd16, reg_op(F7_BASE, F3_ADD_SUB, A0, A0, X7));
        place_word(32'd20, reg_op(F7_SUB, F3_ADD_SUB, A0, A0, X5));
        place_word(32'd24, reg_op(F7_BASE, F3_AND, A0, A0, X7));
        place_word(32'd28, reg_op(F7_BASE, F3_OR, A0, A0, X5));
        place_word(32'd32, reg_op(F7_BASE, F3_XOR, A0, A0, X6));
        place_word(32'd36, reg_op(F7_BASE, F3_SLT, A0, A0, X5));
        place_word(32'd40, upper_imm(A0, 20'hfffff));
        place_word(32'd44, reg_op(F7_BASE, F3_SLT, A0, X5, X6));
        place_word(32'd48, branch_op(F3_BEQ, X5, X5, 32'd12));
        place_word(32'd52, imm_op(A0, X0, 32'd99));
        place_word(32'd56, imm_op(A0, X0, 32'd77));
        place_word(32'd60, branch_op(F3_BNE, X5, X5, 32'd8));
        place_word(32'd64, imm_op(A0, X0, 32'd33));
        place_word(32'd68, jump_link(A0, 32'd12));
        place_word(32'd72, imm_op(A0, X0, 32'd55));
        place_word(32'd76, imm_op(A0, X0, 32'd66));
        place_word(32'd80, imm_op(X0, X0, 32'd5));
        place_word(32'd84, reg_op(F7_BASE, F3_ADD_SUB, A0, X0, X5));
        // ecall is outside the supported set
        place_word(32'd88, instr_u'(32'h0000_0073));
        place_word(32'd92, reg_op(F7_BASE, F3_ADD_SUB, A0, X6, X0));
        place_word(32'd96, jump_link(X0, 32'd0));
    endtask

    task automatic add_row(input string name, input logic [XLEN-1:0] pc,
                           input logic [XLEN-1:0] a0);
        row_t r;
        r.name  = name;
        r.pc    = pc;
        r.instr = prog[pc[7:2]];
        r.a0    = a0;
        exp_rows.push_back(r);
    endtask

    task automatic load_rows();
        add_row("addi x5 12", 32'd0, 32'd0);
        add_row("addi x6 -5", 32'd4, 32'd0);
        add_row("add fwd and write-through", 32'd8, 32'd7);
        add_row("lui x7", 32'd12, 32'd7);
        add_row("add a0 x7", 32'd16, 32'h1234_5007);
        add_row("sub", 32'd20, 32'h1234_4ffb);
        add_row("and", 32'd24, 32'h1234_4000);
        add_row("or", 32'd28, 32'h1234_400c);
        add_row("xor", 32'd32, 32'hedcb_bff7);
        add_row("slt negative", 32'd36, 32'd1);
        add_row("lui a0", 32'd40, 32'hffff_f000);
        add_row("slt false", 32'd44, 32'd0);
        add_row("beq taken", 32'd48, 32'd0);
        add_row("bne not taken", 32'd60, 32'd0);
        add_row("addi after bne", 32'd64, 32'd33);
        add_row("jal link", 32'd68, 32'd72);
        add_row("write x0", 32'd80, 32'd72);
        add_row("x0 not forwarded", 32'd84, 32'd12);
        add_row("unsupported word", 32'd88, 32'd12);
        add_row("add x6 x0", 32'd92, 32'hffff_fffb);
        add_row("jal self loop", 32'd96, 32'hffff_fffb);
        add_row("jal self loop again", 32'd96, 32'hffff_fffb);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("CHECK FAILED %s pc expected %h actual %h",
                                name, exp_val, act_val));
        end
    endtask

    task automatic check_instr(input string name, input instr_u exp_val, input instr_u act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("CHECK FAILED %s instr expected %h actual %h",
                                name, exp_val, act_val));
        end
    endtask

    task automatic check_a0(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("CHECK FAILED %s a0 expected %h actual %h",
                                name, exp_val, act_val));
        end
    endtask

    // sram model answering one request at a time after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (sram_data_valid_i) begin
            req_busy = 1'b0;
        end
        sram_data_valid_i = 1'b0;
        if (sram_ren_o === 1'b1) begin
            if (!req_busy) begin
                req_busy = 1'b1;
                rnd      = $random(seed);
                wait_cnt = rnd[1:0];
            end
            if (wait_cnt == 2'd0) begin
                sram_data_valid_i = 1'b1;
                sram_rdata_i      = read_prog(sram_addr_o);
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

    initial begin
        int   row_idx;
        int   cycles;
        int   max_cycles;
        logic a0_due;
        row_t due_row;

        seed              = 32'hb1b5092c;
        clk               = 1'b0;
        reset_i           = 1'b1;
        sram_rdata_i      = '0;
        sram_data_valid_i = 1'b0;
        req_busy          = 1'b0;
        wait_cnt          = 2'd0;
        load_program();
        load_rows();
        max_cycles = exp_rows.size() * 10 + 40;
        row_idx    = 0;
        cycles     = 0;
        a0_due     = 1'b0;

        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        while (row_idx < exp_rows.size() || a0_due) begin
            @(negedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                abort_run("timeout, retirement stalled");
            end
            // a0 shows the write one cycle after retirement
            if (a0_due) begin
                check_a0(due_row.name, due_row.a0, reg_a0_o);
                a0_due = 1'b0;
            end
            if (retire_valid_o === 1'b1 && row_idx < exp_rows.size()) begin
                due_row = exp_rows[row_idx];
                check_pc(due_row.name, due_row.pc, retire_pc_o);
                check_instr(due_row.name, due_row.instr, retire_instr_o);
                a0_due = 1'b1;
                row_idx++;
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             flush_i,
    input  logic                             fd_valid_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     fd_pc_i,
    input  rv_pipe_pkg::instr_u              fd_instr_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     rs1_val_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     rs2_val_i,
    output logic [4:0]                       rs1_idx_o,
    output logic [4:0]                       rs2_idx_o,
    output logic                             de_valid_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     de_pc_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     de_rs1_val_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     de_rs2_val_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     de_imm_o,
    output logic [4:0]                       de_rs1_idx_o,
    output logic [4:0]                       de_rs2_idx_o,
    output logic [4:0]                       de_rd_idx_o,
    output logic [rv_pipe_pkg::ALU_OP_W-1:0] de_alu_op_o,
    output logic                             de_use_imm_o,
    output logic                             de_wen_o,
    output logic                             de_is_branch_o,
    output logic                             de_branch_ne_o,
    output logic                             de_is_jal_o,
    output rv_pipe_pkg::instr_u              de_instr_o
);
    import rv_pipe_pkg::*;

    logic [XLEN-1:0]     imm;
    logic [4:0]          rd;
    logic [ALU_OP_W-1:0] alu_op;
    logic                use_imm;
    logic                wen;
    logic                is_branch;
    logic                branch_ne;
    logic                is_jal;

    assign rs1_idx_o = fd_instr_i.r_fmt.rs1;
    assign rs2_idx_o = fd_instr_i.r_fmt.rs2;

    always_comb begin
        imm       = '0;
        rd        = fd_instr_i.r_fmt.rd;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        wen       = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        case (fd_instr_i.r_fmt.opcode)
            OP_IMM: begin
                imm = {{20{fd_instr_i.i_fmt.imm12[11]}}, fd_instr_i.i_fmt.imm12};
                rd  = fd_instr_i.i_fmt.rd;
                // only addi
                use_imm = (fd_instr_i.i_fmt.funct3 == F3_ADD_SUB);
                wen     = (fd_instr_i.i_fmt.funct3 == F3_ADD_SUB);
            end
            OP_REG: begin
                wen = 1'b1;
                case ({fd_instr_i.r_fmt.funct7, fd_instr_i.r_fmt.funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
                    default:               wen = 1'b0;
                endcase
            end
            OP_LUI: begin
                imm     = {fd_instr_i.u_fmt.imm20, 12'b0};
                rd      = fd_instr_i.u_fmt.rd;
                alu_op  = ALU_PASSB;
                use_imm = 1'b1;
                wen     = 1'b1;
            end
            OP_BRANCH: begin
                imm = {{19{fd_instr_i.b_fmt.imm12}}, fd_instr_i.b_fmt.imm12,
                       fd_instr_i.b_fmt.imm11, fd_instr_i.b_fmt.imm10_5,
                       fd_instr_i.b_fmt.imm4_1, 1'b0};
                is_branch = (fd_instr_i.b_fmt.funct3 == F3_BEQ)
                         || (fd_instr_i.b_fmt.funct3 == F3_BNE);
                branch_ne = (fd_instr_i.b_fmt.funct3 == F3_BNE);
            end
            OP_JAL: begin
                imm = {{11{fd_instr_i.j_fmt.imm20}}, fd_instr_i.j_fmt.imm20,
                       fd_instr_i.j_fmt.imm19_12, fd_instr_i.j_fmt.imm11,
                       fd_instr_i.j_fmt.imm10_1, 1'b0};
                rd     = fd_instr_i.j_fmt.rd;
                is_jal = 1'b1;
                wen    = 1'b1;
            end
            default: begin
                // unsupported encodings retire as no-ops
                wen = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i || !fd_valid_i) begin
            de_valid_o     <= 1'b0;
            de_wen_o       <= 1'b0;
            de_is_branch_o <= 1'b0;
            de_is_jal_o    <= 1'b0;
            de_instr_o     <= NOP_INSTR;
        end else begin
            de_valid_o     <= 1'b1;
            de_wen_o       <= wen;
            de_is_branch_o <= is_branch;
            de_is_jal_o    <= is_jal;
            de_instr_o     <= fd_instr_i;
        end
    end

    always_ff @(posedge clk) begin
        de_pc_o        <= fd_pc_i;
        de_rs1_val_o   <= rs1_val_i;
        de_rs2_val_o   <= rs2_val_i;
        de_imm_o       <= imm;
        de_rs1_idx_o   <= rs1_idx_o;
        de_rs2_idx_o   <= rs2_idx_o;
        de_rd_idx_o    <= rd;
        de_alu_op_o    <= alu_op;
        de_use_imm_o   <= use_imm;
        de_branch_ne_o <= branch_ne;
    end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             de_valid_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     de_pc_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     de_rs1_val_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     de_rs2_val_i,
    input  logic [rv_pipe_pkg::XLEN-1:0]     de_imm_i,
    input  logic [4:0]                       de_rd_idx_i,
    input  logic [rv_pipe_pkg::ALU_OP_W-1:0] de_alu_op_i,
    input  logic                             de_use_imm_i,
    input  logic                             de_wen_i,
    input  logic                             de_is_branch_i,
    input  logic                             de_branch_ne_i,
    input  logic                             de_is_jal_i,
    input  rv_pipe_pkg::instr_u              de_instr_i,
    input  logic                             fwd_rs1_i,
    input  logic                             fwd_rs2_i,
    output logic                             redirect_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     redirect_pc_o,
    output logic                             ew_valid_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     ew_pc_o,
    output rv_pipe_pkg::instr_u              ew_instr_o,
    output logic [4:0]                       ew_rd_idx_o,
    output logic                             ew_wen_o,
    output logic [rv_pipe_pkg::XLEN-1:0]     ew_result_o
);
    import rv_pipe_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] result;
    logic            taken;

    assign op_a    = fwd_rs1_i ? ew_result_o : de_rs1_val_i;
    assign rs2_val = fwd_rs2_i ? ew_result_o : de_rs2_val_i;
    assign op_b    = de_use_imm_i ? de_imm_i : rs2_val;

    always_comb begin
        case (de_alu_op_i)
            ALU_SUB:   alu_res = op_a - op_b;
            ALU_AND:   alu_res = op_a & op_b;
            ALU_OR:    alu_res = op_a | op_b;
            ALU_XOR:   alu_res = op_a ^ op_b;
            ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASSB: alu_res = op_b;
            default:   alu_res = op_a + op_b;
        endcase
    end

    // link value for jal
    assign result = de_is_jal_i ? de_pc_i + XLEN'(4) : alu_res;

    assign taken = de_is_jal_i || (de_is_branch_i && ((op_a == rs2_val) ^ de_branch_ne_i));

    assign redirect_o    = de_valid_i && taken;
    assign redirect_pc_o = de_pc_i + de_imm_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ew_valid_o <= 1'b0;
            ew_wen_o   <= 1'b0;
            ew_instr_o <= NOP_INSTR;
        end else begin
            ew_valid_o <= de_valid_i;
            ew_wen_o   <= de_valid_i && de_wen_i;
            ew_instr_o <= de_instr_i;
        end
    end

    always_ff @(posedge clk) begin
        ew_pc_o     <= de_pc_i;
        ew_rd_idx_o <= de_rd_idx_i;
        ew_result_o <= result;
    end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [rv_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         redirect_i,
    input  logic [rv_pipe_pkg::XLEN-1:0] redirect_pc_i,
    input  logic [rv_pipe_pkg::XLEN-1:0] sram_rdata_i,
    input  logic                         sram_data_valid_i,
    output logic [rv_pipe_pkg::XLEN-1:0] sram_addr_o,
    output logic                         sram_ren_o,
    output logic                         fd_valid_o,
    output logic [rv_pipe_pkg::XLEN-1:0] fd_pc_o,
    output rv_pipe_pkg::instr_u          fd_instr_o
);
    import rv_pipe_pkg::*;

    localparam logic [1:0] REQ_IDLE = 2'd0;
    localparam logic [1:0] REQ_PEND = 2'd1;
    localparam logic [1:0] REQ_DROP = 2'd2;

    logic [1:0]      req_state;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next_q;
    logic            accept;

    assign sram_addr_o = pc_q;
    assign sram_ren_o  = (req_state != REQ_IDLE);
    // returned word belongs to the current path
    assign accept = (req_state == REQ_PEND) && sram_data_valid_i && !redirect_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_state <= REQ_IDLE;
            pc_q      <= RESET_PC;
            pc_next_q <= RESET_PC;
        end else begin
            case (req_state)
                REQ_IDLE: begin
                    req_state <= REQ_PEND;
                end
                REQ_PEND: begin
                    if (sram_data_valid_i) begin
                        pc_q <= redirect_i ? redirect_pc_i : pc_q + XLEN'(4);
                    end else if (redirect_i) begin
                        // request stays on the bus, new target waits
                        req_state <= REQ_DROP;
                        pc_next_q <= redirect_pc_i;
                    end
                end
                default: begin
                    if (redirect_i) begin
                        pc_next_q <= redirect_pc_i;
                    end
                    if (sram_data_valid_i) begin
                        req_state <= REQ_PEND;
                        pc_q      <= redirect_i ? redirect_pc_i : pc_next_q;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || !accept) begin
            fd_valid_o <= 1'b0;
            fd_instr_o <= NOP_INSTR;
        end else begin
            fd_valid_o <= 1'b1;
            fd_instr_o <= sram_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        fd_pc_o <= pc_q;
    end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic [4:0] de_rs1_idx_i,
    input  logic [4:0] de_rs2_idx_i,
    input  logic [4:0] ew_rd_idx_i,
    input  logic       ew_wen_i,
    input  logic       redirect_i,
    output logic       fwd_rs1_o,
    output logic       fwd_rs2_o,
    output logic       flush_o
);

    logic ew_writes;

    // x0 is never a forwarding source
    assign ew_writes = ew_wen_i && (ew_rd_idx_i != 5'd0);

    assign fwd_rs1_o = ew_writes && (ew_rd_idx_i == de_rs1_idx_i);
    assign fwd_rs2_o = ew_writes && (ew_rd_idx_i == de_rs2_idx_i);

    // squashes fetch-to-decode and decode-to-execute together
    assign flush_o = redirect_i;

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic [4:0]                   rs1_idx_i,
    input  logic [4:0]                   rs2_idx_i,
    input  logic                         wen_i,
    input  logic [4:0]                   rd_idx_i,
    input  logic [rv_pipe_pkg::XLEN-1:0] rd_data_i,
    output logic [rv_pipe_pkg::XLEN-1:0] rs1_val_o,
    output logic [rv_pipe_pkg::XLEN-1:0] rs2_val_o,
    output logic [rv_pipe_pkg::XLEN-1:0] a0_o
);
    import rv_pipe_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    // x0 reads zero, a same-cycle write passes straight through
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wen_i && (rd_idx_i == idx)) begin
            return rd_data_i;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (rd_idx_i != 5'd0)) begin
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    always_comb begin
        rs1_val_o = read_port(rs1_idx_i);
        rs2_val_o = read_port(rs2_idx_i);
    end

    assign a0_o = regs[10];

endmodule

`default_nettype wire

/* hw/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    localparam int XLEN = 32;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_PASSB = 3'd6;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

`default_nettype wire

/* hw/rv_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top #(
    parameter logic [rv_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic [rv_pipe_pkg::XLEN-1:0] sram_rdata_i,
    input  logic                         sram_data_valid_i,
    output logic [rv_pipe_pkg::XLEN-1:0] sram_addr_o,
    output logic                         sram_ren_o,
    output logic                         retire_valid_o,
    output logic [rv_pipe_pkg::XLEN-1:0] retire_pc_o,
    output rv_pipe_pkg::instr_u          retire_instr_o,
    output logic [rv_pipe_pkg::XLEN-1:0] reg_a0_o
);
    import rv_pipe_pkg::*;

    // fetch to decode
    logic                fd_valid;
    logic [XLEN-1:0]     fd_pc;
    instr_u              fd_instr;

    // register read
    logic [4:0]          rs1_idx;
    logic [4:0]          rs2_idx;
    logic [XLEN-1:0]     rs1_val;
    logic [XLEN-1:0]     rs2_val;

    // decode to execute
    logic                de_valid;
    logic [XLEN-1:0]     de_pc;
    logic [XLEN-1:0]     de_rs1_val;
    logic [XLEN-1:0]     de_rs2_val;
    logic [XLEN-1:0]     de_imm;
    logic [4:0]          de_rs1_idx;
    logic [4:0]          de_rs2_idx;
    logic [4:0]          de_rd_idx;
    logic [ALU_OP_W-1:0] de_alu_op;
    logic                de_use_imm;
    logic                de_wen;
    logic                de_is_branch;
    logic                de_branch_ne;
    logic                de_is_jal;
    instr_u              de_instr;

    // writeback and control
    logic [4:0]          ew_rd_idx;
    logic                ew_wen;
    logic [XLEN-1:0]     ew_result;
    logic                redirect;
    logic [XLEN-1:0]     redirect_pc;
    logic                fwd_rs1;
    logic                fwd_rs2;
    logic                flush;

    fetch_unit #(
        .RESET_PC          (RESET_PC)
    ) fetch_unit0 (
        .clk               (clk),
        .reset_i           (reset_i),
        .redirect_i        (flush),
        .redirect_pc_i     (redirect_pc),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_addr_o       (sram_addr_o),
        .sram_ren_o        (sram_ren_o),
        .fd_valid_o        (fd_valid),
        .fd_pc_o           (fd_pc),
        .fd_instr_o        (fd_instr)
    );

    reg_file reg_file0 (
        .clk               (clk),
        .reset_i           (reset_i),
        .rs1_idx_i         (rs1_idx),
        .rs2_idx_i         (rs2_idx),
        .wen_i             (ew_wen),
        .rd_idx_i          (ew_rd_idx),
        .rd_data_i         (ew_result),
        .rs1_val_o         (rs1_val),
        .rs2_val_o         (rs2_val),
        .a0_o              (reg_a0_o)
    );

    decode_stage decode_stage0 (
        .clk               (clk),
        .reset_i           (reset_i),
        .flush_i           (flush),
        .fd_valid_i        (fd_valid),
        .fd_pc_i           (fd_pc),
        .fd_instr_i        (fd_instr),
        .rs1_val_i         (rs1_val),
        .rs2_val_i         (rs2_val),
        .rs1_idx_o         (rs1_idx),
        .rs2_idx_o         (rs2_idx),
        .de_valid_o        (de_valid),
        .de_pc_o           (de_pc),
        .de_rs1_val_o      (de_rs1_val),
        .de_rs2_val_o      (de_rs2_val),
        .de_imm_o          (de_imm),
        .de_rs1_idx_o      (de_rs1_idx),
        .de_rs2_idx_o      (de_rs2_idx),
        .de_rd_idx_o       (de_rd_idx),
        .de_alu_op_o       (de_alu_op),
        .de_use_imm_o      (de_use_imm),
        .de_wen_o          (de_wen),
        .de_is_branch_o    (de_is_branch),
        .de_branch_ne_o    (de_branch_ne),
        .de_is_jal_o       (de_is_jal),
        .de_instr_o        (de_instr)
    );

    hazard_unit hazard_unit0 (
        .de_rs1_idx_i      (de_rs1_idx),
        .de_rs2_idx_i      (de_rs2_idx),
        .ew_rd_idx_i       (ew_rd_idx),
        .ew_wen_i          (ew_wen),
        .redirect_i        (redirect),
        .fwd_rs1_o         (fwd_rs1),
        .fwd_rs2_o         (fwd_rs2),
        .flush_o           (flush)
    );

    // writeback register doubles as the retirement port
    execute_stage execute_stage0 (
        .clk               (clk),
        .reset_i           (reset_i),
        .de_valid_i        (de_valid),
        .de_pc_i           (de_pc),
        .de_rs1_val_i      (de_rs1_val),
        .de_rs2_val_i      (de_rs2_val),
        .de_imm_i          (de_imm),
        .de_rd_idx_i       (de_rd_idx),
        .de_alu_op_i       (de_alu_op),
        .de_use_imm_i      (de_use_imm),
        .de_wen_i          (de_wen),
        .de_is_branch_i    (de_is_branch),
        .de_branch_ne_i    (de_branch_ne),
        .de_is_jal_i       (de_is_jal),
        .de_instr_i        (de_instr),
        .fwd_rs1_i         (fwd_rs1),
        .fwd_rs2_i         (fwd_rs2),
        .redirect_o        (redirect),
        .redirect_pc_o     (redirect_pc),
        .ew_valid_o        (retire_valid_o),
        .ew_pc_o           (retire_pc_o),
        .ew_instr_o        (retire_instr_o),
        .ew_rd_idx_o       (ew_rd_idx),
        .ew_wen_o          (ew_wen),
        .ew_result_o       (ew_result)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds the rv_pipe testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary -sv --top-module rv_pipe_tb -f build.f -o rv_pipe_sim > "$LOG" 2>&1 \
    && ./obj_dir/rv_pipe_sim >> "$LOG" 2>&1 \
    || echo "tests failed" >> "$LOG"

cat "$LOG"

grep -q "tests failed" "$LOG" && exit 1 || exit 0
